//--- common/rv_m_pkg.sv
/*
 * Shared constants of the M extension execution unit
 *   - register width and instruction ID width
 *   - ID codes of the eight multiply/divide operations
 *   - iteration count and counter width of the iterative units
 */
package rv_m_pkg;

    // register width of the core
    localparam int GPR_WIDTH = 32;

    // width of the decoded instruction ID
    localparam int INST_ID_LEN = 5;

    // any ID outside this set is a non-M operation and is ignored
    localparam logic [INST_ID_LEN-1:0] MUL_ID    = INST_ID_LEN'(1);
    localparam logic [INST_ID_LEN-1:0] MULH_ID   = INST_ID_LEN'(2);
    localparam logic [INST_ID_LEN-1:0] MULHSU_ID = INST_ID_LEN'(3);
    localparam logic [INST_ID_LEN-1:0] MULHU_ID  = INST_ID_LEN'(4);
    localparam logic [INST_ID_LEN-1:0] DIV_ID    = INST_ID_LEN'(5);
    localparam logic [INST_ID_LEN-1:0] DIVU_ID   = INST_ID_LEN'(6);
    localparam logic [INST_ID_LEN-1:0] REM_ID    = INST_ID_LEN'(7);
    localparam logic [INST_ID_LEN-1:0] REMU_ID   = INST_ID_LEN'(8);

    // one result bit per cycle in both units
    localparam int ITER_COUNT = GPR_WIDTH;

    // the iteration counter runs from ITER_CNT_INIT down to zero
    localparam int ITER_CNT_W = $clog2(ITER_COUNT);
    localparam logic [ITER_CNT_W-1:0] ITER_CNT_INIT = ITER_CNT_W'(ITER_COUNT - 1);

endpackage

//--- mul/mul_iter.sv
/*
 * Iterative unsigned shift-add multiplier
 *   - one multiplier bit per cycle, ITER_COUNT cycles per product
 *   - full double-width product, held until the next start
 */
module mul_iter (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               start_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]     a_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]     b_i,
    output logic                               done_o,
    output logic [2*rv_m_pkg::GPR_WIDTH-1:0]   product_o
);

    logic                              busy_q;
    logic                              done_q;
    logic [rv_m_pkg::ITER_CNT_W-1:0]   cnt_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]    mcand_q;
    logic [2*rv_m_pkg::GPR_WIDTH-1:0]  prod_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]    addend;
    logic [rv_m_pkg::GPR_WIDTH:0]      acc_sum;

    // the upper half of prod_q is the accumulator, the lower half still
    // holds the multiplier bits that have not been consumed yet
    assign addend  = prod_q[0] ? mcand_q : '0;
    assign acc_sum = {1'b0, prod_q[2*rv_m_pkg::GPR_WIDTH-1:rv_m_pkg::GPR_WIDTH]}
                   + {1'b0, addend};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= rv_m_pkg::ITER_CNT_INIT;
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            prod_q  <= {{rv_m_pkg::GPR_WIDTH{1'b0}}, b_i};
            mcand_q <= a_i;
        end else if (busy_q) begin
            // the carry of the add drops into the top bit on the shift
            prod_q <= {acc_sum, prod_q[rv_m_pkg::GPR_WIDTH-1:1]};
        end
    end

    assign done_o    = done_q;
    assign product_o = prod_q;

endmodule

//--- div/div_iter.sv
/*
 * Iterative unsigned restoring divider
 *   - one quotient bit per cycle, ITER_COUNT cycles per division
 *   - quotient and remainder held until the next start
 *   - zero divisor flag for the sign fix in the wrapper
 */
module div_iter (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             start_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]   a_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]   b_i,
    output logic                             done_o,
    output logic                             div_zero_o,
    output logic [rv_m_pkg::GPR_WIDTH-1:0]   quotient_o,
    output logic [rv_m_pkg::GPR_WIDTH-1:0]   remainder_o
);

    logic                             busy_q;
    logic                             done_q;
    logic                             zero_q;
    logic [rv_m_pkg::ITER_CNT_W-1:0]  cnt_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]   rem_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]   quo_q;
    logic [rv_m_pkg::GPR_WIDTH:0]     rem_shift;
    logic [rv_m_pkg::GPR_WIDTH:0]     rem_diff;
    logic                             fits;

    // quo_q starts out as the dividend and its top bit moves into the
    // partial remainder each cycle while the new quotient bit enters at
    // the bottom
    assign rem_shift = {rem_q, quo_q[rv_m_pkg::GPR_WIDTH-1]};
    assign rem_diff  = rem_shift - {1'b0, b_i};

    // no borrow means the divisor fits into the partial remainder
    assign fits = ~rem_diff[rv_m_pkg::GPR_WIDTH];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            zero_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                zero_q <= (b_i == '0);
                cnt_q  <= rv_m_pkg::ITER_CNT_INIT;
            end else if (busy_q) begin
                if (cnt_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    // a zero divisor always fits, so the quotient fills with ones and the
    // dividend bits pass unchanged into the remainder
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q <= '0;
            quo_q <= a_i;
        end else if (busy_q) begin
            if (fits) begin
                rem_q <= rem_diff[rv_m_pkg::GPR_WIDTH-1:0];
            end else begin
                rem_q <= rem_shift[rv_m_pkg::GPR_WIDTH-1:0];
            end
            quo_q <= {quo_q[rv_m_pkg::GPR_WIDTH-2:0], fits};
        end
    end

    assign done_o      = done_q;
    assign div_zero_o  = zero_q;
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

//--- rtl/m_extend.sv
/*
 * M extension execution unit
 *   - decodes the operation and converts signed operands to magnitudes
 *   - starts the iterative multiplier or divider
 *   - restores the result sign and pulses ready_o with the result
 */
module m_extend (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               ce_i,
    input  logic [rv_m_pkg::INST_ID_LEN-1:0]   instr_id_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]     rs1_val_i,
    input  logic [rv_m_pkg::GPR_WIDTH-1:0]     rs2_val_i,
    output logic                               ready_o,
    output logic [rv_m_pkg::GPR_WIDTH-1:0]     result_o
);

    logic                                is_mul;
    logic                                is_div;
    logic                                rs1_signed;
    logic                                rs2_signed;
    logic                                rs1_neg;
    logic                                rs2_neg;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      rs1_mag;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      rs2_mag;
    logic                                capture;
    logic                                unit_done;

    logic                                busy_q;
    logic                                mul_start_q;
    logic                                div_start_q;
    logic [rv_m_pkg::INST_ID_LEN-1:0]    op_q;
    logic                                a_neg_q;
    logic                                b_neg_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      a_mag_q;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      b_mag_q;

    logic                                mul_done;
    logic [2*rv_m_pkg::GPR_WIDTH-1:0]    mul_product;
    logic [2*rv_m_pkg::GPR_WIDTH-1:0]    mul_product_neg;
    logic                                div_done;
    logic                                div_zero;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      div_quotient;
    logic [rv_m_pkg::GPR_WIDTH-1:0]      div_remainder;
    logic                                sign_diff;
    logic                                quo_neg;

    // unit select and operand signedness
    always_comb begin
        is_mul     = 1'b0;
        is_div     = 1'b0;
        rs1_signed = 1'b0;
        rs2_signed = 1'b0;
        case (instr_id_i)
            rv_m_pkg::MUL_ID, rv_m_pkg::MULH_ID: begin
                is_mul     = 1'b1;
                rs1_signed = 1'b1;
                rs2_signed = 1'b1;
            end
            rv_m_pkg::MULHSU_ID: begin
                is_mul     = 1'b1;
                rs1_signed = 1'b1;
            end
            rv_m_pkg::MULHU_ID: begin
                is_mul = 1'b1;
            end
            rv_m_pkg::DIV_ID, rv_m_pkg::REM_ID: begin
                is_div     = 1'b1;
                rs1_signed = 1'b1;
                rs2_signed = 1'b1;
            end
            rv_m_pkg::DIVU_ID, rv_m_pkg::REMU_ID: begin
                is_div = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // an unsigned operand keeps its sign flag low, which is how MULHSU ends
    // up fixing the sign from rs1 alone
    assign rs1_neg = rs1_signed & rs1_val_i[rv_m_pkg::GPR_WIDTH-1];
    assign rs2_neg = rs2_signed & rs2_val_i[rv_m_pkg::GPR_WIDTH-1];
    assign rs1_mag = rs1_neg ? (~rs1_val_i + 1'b1) : rs1_val_i;
    assign rs2_mag = rs2_neg ? (~rs2_val_i + 1'b1) : rs2_val_i;

    assign unit_done = mul_done | div_done;

    // a new operation may be taken in the cycle the running one finishes
    assign capture = ce_i & (is_mul | is_div) & (~busy_q | unit_done);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= capture & is_mul;
            div_start_q <= capture & is_div;
            if (capture) begin
                busy_q <= 1'b1;
            end else if (unit_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            op_q    <= instr_id_i;
            a_neg_q <= rs1_neg;
            b_neg_q <= rs2_neg;
            a_mag_q <= rs1_mag;
            b_mag_q <= rs2_mag;
        end
    end

    mul_iter mul_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start_q),
        .a_i       (a_mag_q),
        .b_i       (b_mag_q),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    div_iter div_unit (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (div_start_q),
        .a_i         (a_mag_q),
        .b_i         (b_mag_q),
        .done_o      (div_done),
        .div_zero_o  (div_zero),
        .quotient_o  (div_quotient),
        .remainder_o (div_remainder)
    );

    assign mul_product_neg = ~mul_product + 1'b1;
    assign sign_diff       = a_neg_q ^ b_neg_q;

    // RISC-V wants all ones on a zero divisor, whatever the dividend sign
    assign quo_neg = sign_diff & ~div_zero;

    always_comb begin
        case (op_q)
            rv_m_pkg::MUL_ID: begin
                result_o = sign_diff ? mul_product_neg[rv_m_pkg::GPR_WIDTH-1:0]
                                     : mul_product[rv_m_pkg::GPR_WIDTH-1:0];
            end
            rv_m_pkg::MULH_ID, rv_m_pkg::MULHSU_ID, rv_m_pkg::MULHU_ID: begin
                result_o = sign_diff
                    ? mul_product_neg[2*rv_m_pkg::GPR_WIDTH-1:rv_m_pkg::GPR_WIDTH]
                    : mul_product[2*rv_m_pkg::GPR_WIDTH-1:rv_m_pkg::GPR_WIDTH];
            end
            rv_m_pkg::DIV_ID, rv_m_pkg::DIVU_ID: begin
                result_o = quo_neg ? (~div_quotient + 1'b1) : div_quotient;
            end
            rv_m_pkg::REM_ID, rv_m_pkg::REMU_ID: begin
                // the remainder takes the sign of the dividend
                result_o = a_neg_q ? (~div_remainder + 1'b1) : div_remainder;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    assign ready_o = unit_done;

endmodule

//--- sim/tb_clock.sv
/*
 * Testbench clock and reset generator
 *   - 40 ns clock period
 *   - reset held high for the first 10 cycles
 */
module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // reset is released on a falling edge like every other DUT input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- sim/tb_m_extend.sv
/*
 * Testbench top of the M extension unit
 *   - directed and random multiply/divide operations against a reference model
 *   - assertions on result, ready latency and ready pulse width
 *   - watchdog and closing report
 */
module tb_m_extend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W              = rv_m_pkg::GPR_WIDTH;
    localparam int ID_W           = rv_m_pkg::INST_ID_LEN;
    localparam int LATENCY        = rv_m_pkg::ITER_COUNT + 1;
    localparam int CLK_NS         = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 80;
    localparam int RAND_MUL_PAIRS = 200;
    localparam int RAND_DIV_PAIRS = 100;
    localparam int B2B_OPS        = 16;
    localparam int NUM_OPS        = 25 * 4 + RAND_MUL_PAIRS * 4 + RAND_DIV_PAIRS * 4
                                  + 6 * 4 + 2 + B2B_OPS;
    localparam longint WATCHDOG_NS =
        longint'(NUM_OPS * 40 + IDLE_CYCLES + RESET_CYCLES) * CLK_NS;

    logic            clk;
    logic            rst;
    logic            ce;
    logic [ID_W-1:0] instr_id;
    logic [W-1:0]    rs1_val;
    logic [W-1:0]    rs2_val;
    logic            ready;
    logic [W-1:0]    result;

    int              seed = 56;
    int              err_count = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;
    logic            expect_idle = 1'b1;
    logic [W-1:0]    corners [0:4];
    logic [ID_W-1:0] mul_ops [0:3];
    logic [ID_W-1:0] div_ops [0:3];

    tb_clock clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    m_extend dut_i (
        .clk_i      (clk),
        .rst_i      (rst),
        .ce_i       (ce),
        .instr_id_i (instr_id),
        .rs1_val_i  (rs1_val),
        .rs2_val_i  (rs2_val),
        .ready_o    (ready),
        .result_o   (result)
    );

    // no M operation has been issued while expect_idle is set
    idle_check: assert property (@(posedge clk) disable iff (rst) expect_idle |-> !ready)
        else begin
            $display("Fail at %0t: ready_o rose without an M operation", $time);
            err_count++;
        end

    pulse_check: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
        else begin
            $display("Fail at %0t: ready_o stayed high for more than one cycle", $time);
            err_count++;
        end

    // expected results straight from the RISC-V M extension rules
    function automatic logic [W-1:0] ref_model(input logic [ID_W-1:0] op,
                                               input logic [W-1:0] a,
                                               input logic [W-1:0] b);
        longint       sa;
        longint       sb;
        logic [63:0]  ua;
        logic [63:0]  ub;
        logic [63:0]  prod_ss;
        logic [63:0]  prod_su;
        logic [63:0]  prod_uu;
        logic [63:0]  tmp;
        logic [W-1:0] min_val;
        logic         overflow;
        sa       = longint'($signed(a));
        sb       = longint'($signed(b));
        ua       = {{(64 - W){1'b0}}, a};
        ub       = {{(64 - W){1'b0}}, b};
        prod_ss  = sa * sb;
        prod_su  = sa * longint'(ub);
        prod_uu  = ua * ub;
        min_val  = {1'b1, {(W - 1){1'b0}}};
        overflow = (a == min_val) && (b == '1);
        case (op)
            rv_m_pkg::MUL_ID:    return prod_ss[W-1:0];
            rv_m_pkg::MULH_ID:   return prod_ss[2*W-1:W];
            rv_m_pkg::MULHSU_ID: return prod_su[2*W-1:W];
            rv_m_pkg::MULHU_ID:  return prod_uu[2*W-1:W];
            rv_m_pkg::DIV_ID: begin
                if (b == '0) begin
                    return '1;
                end else if (overflow) begin
                    return min_val;
                end
                tmp = sa / sb;
                return tmp[W-1:0];
            end
            rv_m_pkg::DIVU_ID: begin
                if (b == '0) begin
                    return '1;
                end
                tmp = ua / ub;
                return tmp[W-1:0];
            end
            rv_m_pkg::REM_ID: begin
                if (b == '0) begin
                    return a;
                end else if (overflow) begin
                    return '0;
                end
                tmp = sa % sb;
                return tmp[W-1:0];
            end
            rv_m_pkg::REMU_ID: begin
                if (b == '0) begin
                    return a;
                end
                tmp = ua % ub;
                return tmp[W-1:0];
            end
            default: return '0;
        endcase
    endfunction

    // issues one operation on a falling edge and checks latency and result
    task automatic run_op(input logic [ID_W-1:0] op, input logic [W-1:0] a,
                          input logic [W-1:0] b, input bit keep_ce);
        logic [W-1:0] expected;
        int           cycles;
        expected = ref_model(op, a, b);
        cycles   = 0;
        ce       = 1'b1;
        instr_id = op;
        rs1_val  = a;
        rs2_val  = b;
        @(negedge clk);
        while (!ready) begin
            cycles++;
            @(negedge clk);
        end
        latency_check: assert (cycles == LATENCY)
            else begin
                $display("Fail at %0t: op %0d ready_o after %0d cycles, expected %0d",
                         $time, op, cycles, LATENCY);
                err_count++;
            end
        result_check: assert (result === expected)
            else begin
                $display("Fail at %0t: op %0d on %h, %h gave %h, expected %h",
                         $time, op, a, b, result, expected);
                err_count++;
            end
        if (!keep_ce) begin
            ce = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int           errs;
        logic [W-1:0] a;
        logic [W-1:0] b;
        ce          = 1'b0;
        instr_id    = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        corners[0]  = '0;
        corners[1]  = W'(1);
        corners[2]  = '1;
        corners[3]  = {1'b1, {(W - 1){1'b0}}};
        corners[4]  = {1'b0, {(W - 1){1'b1}}};
        mul_ops[0]  = rv_m_pkg::MUL_ID;
        mul_ops[1]  = rv_m_pkg::MULH_ID;
        mul_ops[2]  = rv_m_pkg::MULHSU_ID;
        mul_ops[3]  = rv_m_pkg::MULHU_ID;
        div_ops[0]  = rv_m_pkg::DIV_ID;
        div_ops[1]  = rv_m_pkg::DIVU_ID;
        div_ops[2]  = rv_m_pkg::REM_ID;
        div_ops[3]  = rv_m_pkg::REMU_ID;
        wait (rst === 1'b0);
        @(negedge clk);

        // ce_i held high with IDs outside the M set
        errs = err_count;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            ce       = 1'b1;
            instr_id = (i % 2 == 0) ? '0 : ID_W'(9 + i % 23);
            rs1_val  = $random(seed);
            rs2_val  = $random(seed);
            @(negedge clk);
            no_ready_check: assert (!ready)
                else begin
                    $display("Fail at %0t: ready_o high for non-M ID %0d", $time, instr_id);
                    err_count++;
                end
        end
        ce = 1'b0;
        @(negedge clk);
        expect_idle = 1'b0;
        report_test("reset and non-M IDs", errs);

        errs = err_count;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 4; k++) begin
                    run_op(mul_ops[k], corners[i], corners[j], 1'b0);
                end
            end
        end
        for (int n = 0; n < RAND_MUL_PAIRS; n++) begin
            a = $random(seed);
            b = $random(seed);
            for (int k = 0; k < 4; k++) begin
                run_op(mul_ops[k], a, b, 1'b0);
            end
        end
        report_test("multiply", errs);

        // every other pair uses a small divisor to get wider quotients
        errs = err_count;
        for (int n = 0; n < RAND_DIV_PAIRS; n++) begin
            a = $random(seed);
            b = $random(seed);
            if (n % 2 == 1) begin
                b = {{(W - 12){b[W-1]}}, b[11:0]};
            end
            for (int k = 0; k < 4; k++) begin
                run_op(div_ops[k], a, b, 1'b0);
            end
        end
        report_test("divide", errs);

        errs = err_count;
        for (int i = 0; i < 6; i++) begin
            a = (i < 5) ? corners[i] : W'($random(seed));
            for (int k = 0; k < 4; k++) begin
                run_op(div_ops[k], a, '0, 1'b0);
            end
        end
        run_op(rv_m_pkg::DIV_ID, corners[3], '1, 1'b0);
        run_op(rv_m_pkg::REM_ID, corners[3], '1, 1'b0);
        report_test("divide by zero and overflow", errs);

        // ce_i stays high and new operands follow each ready pulse
        errs = err_count;
        for (int n = 0; n < B2B_OPS; n++) begin
            a = $random(seed);
            b = $random(seed);
            if (n % 2 == 0) begin
                run_op(mul_ops[(n / 2) % 4], a, b, n != B2B_OPS - 1);
            end else begin
                run_op(div_ops[(n / 2) % 4], a, b, n != B2B_OPS - 1);
            end
        end
        report_test("back-to-back", errs);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: simulation timed out after %0d ns, the DUT stopped answering",
                 WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- compile.f
common/rv_m_pkg.sv
mul/mul_iter.sv
div/div_iter.sv
rtl/m_extend.sv
sim/tb_clock.sv
sim/tb_m_extend.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_m_extend \
    && ./obj_dir/Vtb_m_extend > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Finished with no errors$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
